//--- bench/bottomTests.mem
// Columns: kind(1) pc(4) field(2) data(2) flags(1)
// 1 op: opcode, imm; 2 APB write, 3 APB read: addr, data; 4 result: pc, {irq,wr,dst}, value, ZNHC
// 5 trigger: data; 6 drain then A equals pc; 0 end
10000063C0
40100083C0
1000048000
40102093C0
1000079000
401030F3C0
10000160F0
401040A0F0
100005A000
401060B0F0
1000026FF0
401070CFF0
100002E000
401090D000
6010B00000
// ALU flags
1000082000
4010B0F4B2
1000084000
4010C0F4A3
1000092000
4010D0F3B6
10000B8000
4010E00007
10000BF000
4010F0000C
10000A2000
401100F0B2
10000AF000
401110F008
10000B0000
401120F3C0
1000094000
401130F3D7
// INC and DEC keep C
1000024000
401140C00B
1000015000
401150A0E5
100001C000
401160B103
100002D000
401170DFF7
100002C000
401180D00B
1000025000
401190CFF7
100002C000
4011A0D011
6011B00000
// (HL) and unsupported codes
1000046000
4011B00001
1000036990
4011C00001
1000086000
4011D00001
1000034000
4011E00001
1000088000
4011F00001
1000000000
4012000001
10000C3000
4012100001
1000078000
401220F3C1
6012300000
// APB registers
2000000A50
3000000A50
20000015A0
30000015A0
3000002230
3000003010
3000004FE0
2000001000
3000001000
// Interrupt dispatch, bit 2 wins over bit 3
20000000C0
20000010E0
10000FB000
4012300001
1000006110
4012488111
1000048000
4005009111
1000016220
400510A221
6005300000
3000004FC0
30000010A0
2000001000
10000FB000
4005300001
10000F3000
4005400001
6005500000
5000000040
3000001040
100001E330
400550B331
6005700000
10000FB000
4005700001
100003E440
400588F441
100006F000
400500D441
6005100000
3000004FA0
3000001000
0000000000

//--- bench/gbBottomTb.sv
`timescale 1ns/1ps
`default_nettype none

module gbBottomTb;

	localparam logic [15:0] resetPc = 16'h0100;
	localparam logic [15:0] resetSp = 16'hFFFE;
	localparam int timeoutCycles = 200;
	localparam int maxRecords = 256;

	logic CLK = 1'b0;
	logic arstN;
	logic opValid;
	logic opReady;
	bottomPkg::opWord op;
	logic resValid;
	logic resReady;
	bottomPkg::resWord res;
	logic psel;
	logic penable;
	logic pwrite;
	logic [2:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic [7:0] irqTrig;
	logic [15:0] A;

	// Record is kind, pc, field byte, data byte, flags nibble
	logic [39:0] tests [maxRecords];
	logic [39:0] expQ [$];	// Expected results in retire order
	logic [31:0] lcgState;

	always #2 CLK = ~CLK;

	gbBottom #(
		.resetPc(resetPc),
		.resetSp(resetSp)
	) gbBottom_i (
		.CLK(CLK),
		.arstN(arstN),
		.opValid(opValid),
		.opReady(opReady),
		.op(op),
		.resValid(resValid),
		.resReady(resReady),
		.res(res),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.irqTrig(irqTrig),
		.A(A)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compareVal(input string name, input logic [15:0] exp, input logic [15:0] got);
		if (got !== exp)
			abortRun($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic checkResult(input logic [39:0] rec);
		compareVal("res.pc", rec[35:20], res.pc);
		compareVal("res.irqTaken", 16'(rec[19]), 16'(res.irqTaken));
		compareVal("res.wr", 16'(rec[15]), 16'(res.wr));
		if (rec[15]) begin	// Target and value only matter on a write
			compareVal("res.dst", 16'(rec[14:12]), 16'(res.dst));
			compareVal("res.value", 16'(rec[11:4]), 16'(res.value));
		end
		compareVal("res.flags", 16'(rec[3:0]), 16'(res.flags));
	endtask

	task automatic sendOp(input logic [7:0] opcode, input logic [7:0] imm);
		int waited;
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		opValid = 1'b1;
		op.opcode = opcode;
		op.imm = imm;
		while (!accepted) begin
			@(negedge CLK);
			accepted = opReady;	// Stable until the next edge
			@(posedge CLK);
			#1;
			waited++;
			if (!accepted && waited >= timeoutCycles)
				abortRun("instruction was not accepted in time");
		end
		opValid = 1'b0;
		op = '0;
	endtask

	task automatic apbTransfer(input logic write, input logic [2:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		rdata = 8'h00;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge CLK);
		#1;
		penable = 1'b1;	// Access phase
		while (!done) begin
			@(negedge CLK);
			done = pready;
			rdata = prdata;
			@(posedge CLK);
			#1;
			waited++;
			if (!done && waited >= timeoutCycles)
				abortRun("APB transfer got no pready in time");
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbReadCheck(input logic [2:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		apbTransfer(1'b0, addr, 8'h00, got);
		compareVal($sformatf("prdata@%0d", addr), 16'(exp), 16'(got));
	endtask

	task automatic pulseTrig(input logic [7:0] pattern);
		irqTrig = pattern;
		@(posedge CLK);
		#1;
		irqTrig = 8'h00;
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expQ.size() != 0) begin
			@(posedge CLK);
			#1;
			waited++;
			if (waited >= timeoutCycles && expQ.size() != 0)
				abortRun("expected results did not all arrive in time");
		end
	endtask

	task automatic runRecords();
		logic [39:0] rec;
		logic [7:0] unused;
		logic done;
		int i;
		done = 1'b0;
		for (i = 0; i < maxRecords && !done; i++) begin
			rec = tests[i];
			case (rec[39:36])
				4'h0: done = 1'b1;
				4'h1: sendOp(rec[19:12], rec[11:4]);
				4'h2: apbTransfer(1'b1, rec[14:12], rec[11:4], unused);
				4'h3: apbReadCheck(rec[14:12], rec[11:4]);
				4'h4: expQ.push_back(rec);
				4'h5: pulseTrig(rec[11:4]);
				4'h6: begin
					waitDrain();
					compareVal("A", rec[35:20], A);
				end
				default: abortRun($sformatf("test record %0d has an unknown kind", i));
			endcase
		end
		if (!done)
			abortRun("test file has no end record");
	endtask

	// Results are checked where they are stable, before the transfer edge
	always @(negedge CLK) begin
		if (arstN && resValid && resReady) begin
			if (expQ.size() == 0)
				abortRun("a result arrived that no test record expects");
			else
				checkResult(expQ.pop_front());
		end
	end

	// Random back-pressure, low about a quarter of the time
	initial begin
		lcgState = 32'd76;
		resReady = 1'b0;
		forever begin
			@(posedge CLK);
			#1;
			lcgState = lcgNext(lcgState);
			resReady = (lcgState[17:16] != 2'b00);
		end
	end

	initial begin
		arstN = 1'b0;
		opValid = 1'b0;
		op = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 3'd0;
		pwdata = 8'h00;
		irqTrig = 8'h00;
		$readmemh("bench/bottomTests.mem", tests);
		repeat (5) @(posedge CLK);
		#1;
		arstN = 1'b1;
		runRecords();
		waitDrain();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- gbBottom.f
source/bottomPkg.sv
source/opDecode.sv
source/regExec.sv
source/retireUnit.sv
source/irqRegs.sv
source/gbBottom.sv
bench/gbBottomTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --top-module gbBottomTb \
	-f gbBottom.f -Mdir obj_dir -o gbBottomSim

./obj_dir/gbBottomSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

//--- source/bottomPkg.sv
`default_nettype none

package bottomPkg;

	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] imm;
	} opWord;

	typedef enum logic [3:0] {
		nop, ld, ldImm, inc, dec, add, sub, andOp, xorOp, orOp, cp, ei, di
	} aluOp;

	// SM83 operand order B C D E H L (HL) A
	localparam logic [2:0] regHl = 3'd6;
	localparam logic [2:0] regA = 3'd7;

	typedef struct packed {
		logic valid;
		aluOp op;
		logic [2:0] src;
		logic [2:0] dst;
		logic [7:0] imm;
		logic [1:0] len;
		logic [7:0] opcode;	// Raw opcode, kept for tests
	} decWord;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flagBits;

	typedef struct packed {
		logic valid;
		logic wr;
		logic [2:0] dst;
		logic [7:0] value;
		flagBits flags;
		logic [1:0] len;
		logic eiMark;
		logic diMark;
	} exWord;

	typedef struct packed {
		logic [15:0] pc;
		logic wr;
		logic [2:0] dst;
		logic [7:0] value;
		flagBits flags;
		logic irqTaken;
		logic pad;
	} resWord;

	// APB word addresses
	localparam logic [2:0] apbIe = 3'd0;
	localparam logic [2:0] apbIf = 3'd1;
	localparam logic [2:0] apbPcLo = 3'd2;
	localparam logic [2:0] apbPcHi = 3'd3;
	localparam logic [2:0] apbSp = 3'd4;

	localparam logic [7:0] irqVectorBase = 8'h40;

endpackage

`default_nettype wire

//--- source/gbBottom.sv
`timescale 1ns/1ps
`default_nettype none

module gbBottom #(
	parameter logic [15:0] resetPc = 16'h0100,
	parameter logic [15:0] resetSp = 16'hFFFE
) (
	input logic CLK,
	input logic arstN,
	input logic opValid,
	output logic opReady,
	input bottomPkg::opWord op,
	output logic resValid,
	input logic resReady,
	output bottomPkg::resWord res,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [2:0] paddr,
	input logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	input logic [7:0] irqTrig,
	output logic [15:0] A	// Current PC
);

	logic stall;	// Freezes all three stages
	bottomPkg::decWord dec;
	bottomPkg::exWord ex;
	logic [7:0] irqPending;
	logic [7:0] irqClr;
	logic [15:0] sp;

	opDecode opDecode_i (
		.CLK(CLK),
		.arstN(arstN),
		.stall(stall),
		.opValid(opValid),
		.opReady(opReady),
		.op(op),
		.dec(dec)
	);

	regExec regExec_i (
		.CLK(CLK),
		.arstN(arstN),
		.stall(stall),
		.dec(dec),
		.ex(ex)
	);

	retireUnit #(
		.resetPc(resetPc),
		.resetSp(resetSp)
	) retireUnit_i (
		.CLK(CLK),
		.arstN(arstN),
		.ex(ex),
		.irqPending(irqPending),
		.irqClr(irqClr),
		.resValid(resValid),
		.resReady(resReady),
		.res(res),
		.stall(stall),
		.pc(A),
		.sp(sp)
	);

	irqRegs irqRegs_i (
		.CLK(CLK),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.irqTrig(irqTrig),
		.irqClr(irqClr),
		.pc(A),
		.sp(sp),
		.irqPending(irqPending)
	);

endmodule

`default_nettype wire

//--- source/irqRegs.sv
`timescale 1ns/1ps
`default_nettype none

module irqRegs (
	input logic CLK,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [2:0] paddr,
	input logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	input logic [7:0] irqTrig,
	input logic [7:0] irqClr,
	input logic [15:0] pc,
	input logic [15:0] sp,
	output logic [7:0] irqPending
);

	logic [7:0] ie;
	logic [7:0] ifReg;
	logic [7:0] ifNext;
	logic wrAccess;

	assign pready = 1'b1;
	assign wrAccess = psel && penable && pready && pwrite;
	assign irqPending = ie & ifReg;

	always_comb begin
		ifNext = ifReg;
		if (wrAccess && paddr == bottomPkg::apbIf)
			ifNext = pwdata;
		ifNext = (ifNext | irqTrig) & ~irqClr;	// Write, set, then clear
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ie <= 8'h00;
			ifReg <= 8'h00;
		end else begin
			if (wrAccess && paddr == bottomPkg::apbIe)
				ie <= pwdata;
			ifReg <= ifNext;
		end
	end

	always_comb begin
		case (paddr)
			bottomPkg::apbIe: prdata = ie;
			bottomPkg::apbIf: prdata = ifReg;
			bottomPkg::apbPcLo: prdata = pc[7:0];
			bottomPkg::apbPcHi: prdata = pc[15:8];
			bottomPkg::apbSp: prdata = sp[7:0];	// Low byte only
			default: prdata = 8'h00;
		endcase
	end

	assert property (@(posedge CLK) disable iff (!arstN) penable |-> psel);

endmodule

`default_nettype wire

//--- source/opDecode.sv
`timescale 1ns/1ps
`default_nettype none

module opDecode (
	input logic CLK,
	input logic arstN,
	input logic stall,
	input logic opValid,
	output logic opReady,
	input bottomPkg::opWord op,
	output bottomPkg::decWord dec
);

	bottomPkg::decWord decNext;
	logic [2:0] lo;	// yyy field
	logic [2:0] hi;	// xxx field

	assign opReady = !stall;
	assign lo = op.opcode[2:0];
	assign hi = op.opcode[5:3];

	always_comb begin
		decNext = '0;
		decNext.valid = opValid && opReady;
		decNext.op = bottomPkg::nop;
		decNext.src = lo;
		decNext.dst = hi;
		decNext.imm = op.imm;
		decNext.len = 2'd1;
		decNext.opcode = op.opcode;
		case (op.opcode[7:6])
			2'b01: begin
				if (lo != bottomPkg::regHl && hi != bottomPkg::regHl)
					decNext.op = bottomPkg::ld;
			end
			2'b00: begin
				if (hi != bottomPkg::regHl) begin
					if (lo == 3'b110) begin
						decNext.op = bottomPkg::ldImm;
						decNext.len = 2'd2;
					end else if (lo[2:1] == 2'b10) begin
						decNext.src = hi;	// Operand is the target itself
						if (lo[0])
							decNext.op = bottomPkg::dec;
						else
							decNext.op = bottomPkg::inc;
					end
				end
			end
			2'b10: begin
				if (lo != bottomPkg::regHl) begin
					decNext.dst = bottomPkg::regA;
					case (hi)
						3'd0: decNext.op = bottomPkg::add;
						3'd2: decNext.op = bottomPkg::sub;
						3'd4: decNext.op = bottomPkg::andOp;
						3'd5: decNext.op = bottomPkg::xorOp;
						3'd6: decNext.op = bottomPkg::orOp;
						3'd7: decNext.op = bottomPkg::cp;
						default: decNext.op = bottomPkg::nop;	// ADC, SBC
					endcase
				end
			end
			default: begin
				if (op.opcode == 8'hFB)
					decNext.op = bottomPkg::ei;
				else if (op.opcode == 8'hF3)
					decNext.op = bottomPkg::di;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			dec <= '0;
		else if (!stall)
			dec <= decNext;
	end

	assert property (@(posedge CLK) disable iff (!arstN)
		dec.valid |-> (dec.len == 2'd1 || dec.len == 2'd2));

endmodule

`default_nettype wire

//--- source/regExec.sv
`timescale 1ns/1ps
`default_nettype none

module regExec (
	input logic CLK,
	input logic arstN,
	input logic stall,
	input bottomPkg::decWord dec,
	output bottomPkg::exWord ex
);

	logic [7:0] rf [8];	// Slot 6 stands for (HL) and stays unused
	bottomPkg::flagBits f;
	bottomPkg::flagBits fNext;
	bottomPkg::exWord exNext;
	logic [7:0] srcVal;
	logic [7:0] aVal;
	logic [7:0] result;
	logic [8:0] addFull;
	logic [4:0] addHalf;
	logic [8:0] subFull;	// Bit 8 is the borrow
	logic [4:0] subHalf;
	logic wr;
	logic touchF;

	assign srcVal = rf[dec.src];
	assign aVal = rf[bottomPkg::regA];
	assign addFull = {1'b0, aVal} + {1'b0, srcVal};
	assign addHalf = {1'b0, aVal[3:0]} + {1'b0, srcVal[3:0]};
	assign subFull = {1'b0, aVal} - {1'b0, srcVal};
	assign subHalf = {1'b0, aVal[3:0]} - {1'b0, srcVal[3:0]};

	always_comb begin
		result = srcVal;
		fNext = f;
		wr = 1'b0;
		touchF = 1'b1;
		case (dec.op)
			bottomPkg::ld: begin
				wr = 1'b1;
				touchF = 1'b0;
			end
			bottomPkg::ldImm: begin
				result = dec.imm;
				wr = 1'b1;
				touchF = 1'b0;
			end
			bottomPkg::inc: begin
				result = srcVal + 8'd1;
				wr = 1'b1;
				fNext.n = 1'b0;
				fNext.h = (srcVal[3:0] == 4'hF);	// C kept
			end
			bottomPkg::dec: begin
				result = srcVal - 8'd1;
				wr = 1'b1;
				fNext.n = 1'b1;
				fNext.h = (srcVal[3:0] == 4'h0);
			end
			bottomPkg::add: begin
				result = addFull[7:0];
				wr = 1'b1;
				fNext.n = 1'b0;
				fNext.h = addHalf[4];
				fNext.c = addFull[8];
			end
			bottomPkg::sub, bottomPkg::cp: begin
				result = subFull[7:0];
				wr = (dec.op == bottomPkg::sub);	// CP only compares
				fNext.n = 1'b1;
				fNext.h = subHalf[4];
				fNext.c = subFull[8];
			end
			bottomPkg::andOp: begin
				result = aVal & srcVal;
				wr = 1'b1;
				fNext = '{z: 1'b0, n: 1'b0, h: 1'b1, c: 1'b0};
			end
			bottomPkg::xorOp, bottomPkg::orOp: begin
				result = (dec.op == bottomPkg::xorOp) ? (aVal ^ srcVal) : (aVal | srcVal);
				wr = 1'b1;
				fNext = '0;
			end
			default: touchF = 1'b0;	// NOP, EI, DI
		endcase
		if (touchF)
			fNext.z = (result == 8'h00);

		exNext.valid = dec.valid;
		exNext.wr = dec.valid && wr;
		exNext.dst = dec.dst;
		exNext.value = result;
		exNext.flags = fNext;
		exNext.len = dec.len;
		exNext.eiMark = (dec.op == bottomPkg::ei);
		exNext.diMark = (dec.op == bottomPkg::di);
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++)
				rf[i] <= 8'h00;
			f <= '0;
			ex <= '0;
		end else if (!stall) begin
			if (exNext.wr)
				rf[dec.dst] <= result;	// Visible to the next execute cycle
			if (dec.valid)
				f <= fNext;
			ex <= exNext;
		end
	end

	assert property (@(posedge CLK) disable iff (!arstN)
		ex.valid && ex.wr |-> ex.dst != bottomPkg::regHl);

endmodule

`default_nettype wire

//--- source/retireUnit.sv
`timescale 1ns/1ps
`default_nettype none

module retireUnit #(
	parameter logic [15:0] resetPc = 16'h0100,
	parameter logic [15:0] resetSp = 16'hFFFE
) (
	input logic CLK,
	input logic arstN,
	input bottomPkg::exWord ex,
	input logic [7:0] irqPending,
	output logic [7:0] irqClr,
	output logic resValid,
	input logic resReady,
	output bottomPkg::resWord res,
	output logic stall,
	output logic [15:0] pc,
	output logic [15:0] sp
);

	logic ime;
	logic take;
	logic [2:0] irqIdx;
	logic [15:0] vector;

	assign stall = resValid && !resReady;
	assign take = ex.valid && ime && (irqPending != 8'h00);
	assign vector = {8'h00, bottomPkg::irqVectorBase + {2'b00, irqIdx, 3'b000}};

	// Lowest pending bit wins
	always_comb begin
		irqIdx = 3'd0;
		for (int i = 7; i >= 0; i--)
			if (irqPending[i])
				irqIdx = 3'(i);
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
			sp <= resetSp;
			ime <= 1'b0;
			resValid <= 1'b0;
			irqClr <= '0;
		end else begin
			irqClr <= '0;
			if (!stall) begin
				resValid <= ex.valid;
				if (take) begin
					pc <= vector;
					sp <= sp - 16'd2;	// Room for the pushed PC
					ime <= 1'b0;
					irqClr <= 8'd1 << irqIdx;
				end else if (ex.valid) begin
					pc <= pc + {14'd0, ex.len};
					if (ex.eiMark)
						ime <= 1'b1;
					else if (ex.diMark)
						ime <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall && ex.valid) begin
			res.pc <= pc;
			res.wr <= ex.wr;
			res.dst <= ex.dst;
			res.value <= ex.value;
			res.flags <= ex.flags;
			res.irqTaken <= take;
			res.pad <= 1'b0;
		end
	end

	assert property (@(posedge CLK) disable iff (!arstN) $onehot0(irqClr));

endmodule

`default_nettype wire
